/* dv/rsync_props.sv */
`default_nettype none

module rsync_props (
    input wire                       clkin_binary_0,
    input wire                       clkinb_binary_0,
    input wire                       pdb,
    input dac_ctrl_pkg::atb_sel_t    atb_ena,
    input dac_code_pkg::therm_word_t dataintherm,
    input dac_ctrl_pkg::fault_t      fault_d,     // Decoder flags before the pipeline
    input dac_code_pkg::bin_word_t   dataoutbin,
    input dac_code_pkg::bin_word_t   dataoutbinb,
    input dac_code_pkg::therm_word_t dataouttherm,
    input dac_code_pkg::therm_word_t dataoutthermb,
    input dac_ctrl_pkg::fault_t      atb1,
    input dac_ctrl_pkg::fault_t      atb0
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0; // Read by the testbench at the end of the run
    logic        outs_zero;
    logic        fill_ok;

    assign outs_zero = (dataoutbin == '0) && (dataoutbinb == '0) && (dataouttherm == '0)
                       && (dataoutthermb == '0) && (atb1 == '0) && (atb0 == '0);

    // Contiguous fill from bit 0, adding one carries through every set bit
    assign fill_ok = ((dataintherm & (dataintherm + dac_code_pkg::therm_word_t'(1))) == '0);

    reset_clears: assert property (@(posedge clkin_binary_0) !clkinb_binary_0 |-> outs_zero)
        else begin
            $error("outputs not all zero while reset is held");
            fail_count++;
        end

    first_edge_clear: assert property (@(posedge clkin_binary_0)
        $rose(clkinb_binary_0) |-> outs_zero ##1 outs_zero)
        else begin
            $error("outputs not all zero on the first edge after reset");
            fail_count++;
        end

    pdb_forces_zero: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        !pdb |=> outs_zero)
        else begin
            $error("outputs not all zero one cycle after pdb was low");
            fail_count++;
        end

    fill_no_bubble: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        fill_ok |-> !fault_d[dac_ctrl_pkg::FLT_THERM_BUBBLE])
        else begin
            $error("bubble flagged on a valid thermometric fill");
            fail_count++;
        end

    atb_off_quiet: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        (atb_ena == dac_ctrl_pkg::atb_off) |-> (atb1 == '0) && (atb0 == '0))
        else begin
            $error("test bus active while atb_ena selects off");
            fail_count++;
        end

    // Sticky flags never drop while shown, and both buses carry them
    sticky_holds: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        (atb_ena == dac_ctrl_pkg::atb_sticky) && $past(atb_ena == dac_ctrl_pkg::atb_sticky)
        && $past(pdb) && $past(pdb, 2)
        |-> ((atb1 & $past(atb1)) == $past(atb1)) && (atb1 == atb0))
        else begin
            $error("sticky flags dropped or atb1 and atb0 differ");
            fail_count++;
        end

endmodule

bind rsync_latch_top rsync_props u_props (
    .clkin_binary_0  (clkin_binary_0),
    .clkinb_binary_0 (clkinb_binary_0),
    .pdb             (pdb),
    .atb_ena         (atb_ena),
    .dataintherm     (dataintherm),
    .fault_d         (fault_d),
    .dataoutbin      (dataoutbin),
    .dataoutbinb     (dataoutbinb),
    .dataouttherm    (dataouttherm),
    .dataoutthermb   (dataoutthermb),
    .atb1            (atb1),
    .atb0            (atb0)
);

`default_nettype wire

/* dv/rsync_tb.sv */
`default_nettype none

`include "rsync_settings.svh"

module rsync_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int BW           = `BIN_WIDTH;
    localparam int TW           = `THERM_WIDTH;
    localparam int STAGES       = `RSYNC_STAGES;
    localparam int WORD_W       = 2 * BW + 2 * TW + dac_ctrl_pkg::FAULT_W;
    localparam int N_RANDOM     = 40;
    localparam int N_BUBBLE     = 20;
    localparam int N_PDB        = 30;
    localparam int N_ATB        = 24;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + (TW + 1) + N_RANDOM + N_BUBBLE
                                  + N_PDB + N_ATB + STAGES + 2;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD * 3 / 2;

    logic                      clkin_binary_0;
    logic                      clkinb_binary_0;
    logic                      pdb;
    dac_ctrl_pkg::atb_sel_t    atb_ena;
    dac_code_pkg::bin_word_t   datainbin, datainbinb;
    dac_code_pkg::therm_word_t dataintherm, datainthermb;
    dac_code_pkg::bin_word_t   dataoutbin, dataoutbinb;
    dac_code_pkg::therm_word_t dataouttherm, dataoutthermb;
    dac_ctrl_pkg::fault_t      atb1, atb0;

    logic [WORD_W-1:0]         in_flight [$];      // Words inside the resync pipeline
    dac_code_pkg::bin_word_t   exp_bin, exp_binb;
    dac_code_pkg::therm_word_t exp_therm, exp_thermb;
    dac_ctrl_pkg::fault_t      exp_live, exp_sticky;
    logic                      exp_pdb_r;
    logic [15:0]               lfsr   = 16'd21;
    int                        errors = 0;

    dac_code_pkg::bin_word_t   pending_bt, pending_bc;
    dac_code_pkg::therm_word_t pending_tt, pending_tc;

    rsync_latch_top u_dut (.*);

    initial begin
        clkin_binary_0 = 1'b0;
        forever #(CLK_PERIOD / 2) clkin_binary_0 = ~clkin_binary_0;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the stimulus finished");
        $display("STATUS: FAIL");
        $finish;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic dac_code_pkg::therm_word_t therm_fill(input int k);
        dac_code_pkg::therm_word_t w;
        w = '0;
        for (int i = 0; i < k; i++) begin
            w[i] = 1'b1;
        end
        return w;
    endfunction

    function automatic dac_ctrl_pkg::fault_t expected_fault(
        input dac_code_pkg::bin_word_t bt, input dac_code_pkg::bin_word_t bc,
        input dac_code_pkg::therm_word_t tt, input dac_code_pkg::therm_word_t tc);
        dac_ctrl_pkg::fault_t f;
        f = '0;
        for (int i = 0; i < BW; i++) begin
            if (bt[i] == bc[i]) f[dac_ctrl_pkg::FLT_BIN_PAIR] = 1'b1;
        end
        for (int i = 0; i < TW; i++) begin
            if (tt[i] == tc[i]) f[dac_ctrl_pkg::FLT_THERM_PAIR] = 1'b1;
        end
        // Only 2**n-1 is a fill from bit 0
        f[dac_ctrl_pkg::FLT_THERM_BUBBLE] = ((tt & (tt + dac_code_pkg::therm_word_t'(1))) != '0);
        return f;
    endfunction

    // Applies the rising edge that just passed, using the inputs it sampled
    task automatic model_edge();
        logic [WORD_W-1:0] leaving;
        in_flight.push_back({datainbin, datainbinb, dataintherm, datainthermb,
                             expected_fault(datainbin, datainbinb, dataintherm, datainthermb)});
        leaving   = in_flight.pop_front();
        exp_pdb_r = pdb;
        if (pdb) begin
            {exp_bin, exp_binb, exp_therm, exp_thermb, exp_live} = leaving;
            exp_sticky = exp_sticky | leaving[dac_ctrl_pkg::FAULT_W-1:0];
        end else begin
            {exp_bin, exp_binb, exp_therm, exp_thermb, exp_live} = '0; // Sticky keeps its value
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        dac_ctrl_pkg::fault_t exp_atb1;
        dac_ctrl_pkg::fault_t exp_atb0;
        exp_atb1 = '0;
        exp_atb0 = '0;
        if (exp_pdb_r) begin
            case (atb_ena)
                dac_ctrl_pkg::atb_live, dac_ctrl_pkg::atb_live_alt: exp_atb1 = exp_live;
                dac_ctrl_pkg::atb_sticky: begin
                    exp_atb1 = exp_sticky;
                    exp_atb0 = exp_sticky;
                end
                default: ;
            endcase
        end
        compare_value("dataoutbin", 32'(dataoutbin), 32'(exp_bin));
        compare_value("dataoutbinb", 32'(dataoutbinb), 32'(exp_binb));
        compare_value("dataouttherm", 32'(dataouttherm), 32'(exp_therm));
        compare_value("dataoutthermb", 32'(dataoutthermb), 32'(exp_thermb));
        compare_value("atb1", 32'(atb1), 32'(exp_atb1));
        compare_value("atb0", 32'(atb0), 32'(exp_atb0));
    endtask

    task automatic drive_cycle(
        input dac_code_pkg::bin_word_t bt, input dac_code_pkg::bin_word_t bc,
        input dac_code_pkg::therm_word_t tt, input dac_code_pkg::therm_word_t tc,
        input logic p, input dac_ctrl_pkg::atb_sel_t sel);
        @(negedge clkin_binary_0);
        model_edge();
        check_outputs();
        datainbin    = bt;
        datainbinb   = bc;
        dataintherm  = tt;
        datainthermb = tc;
        pdb          = p;
        atb_ena      = sel;
    endtask

    // Valid fill word with optional pair corruption and bubbles
    task automatic random_word(input bit pair_faults, input bit bubbles);
        logic [31:0]               r;
        dac_code_pkg::therm_word_t m;
        dac_code_pkg::bin_word_t   bt, bc;
        dac_code_pkg::therm_word_t tt, tc;
        random_bits(BW, r);
        bt = dac_code_pkg::bin_word_t'(r);
        random_bits(5, r);
        tt = therm_fill(int'(r % (TW + 1)));
        bc = ~bt;
        tc = ~tt;
        if (pair_faults) begin
            random_bits(4, r);
            if (r[3]) bc[r[2:0] % BW] = bt[r[2:0] % BW];
            random_bits(6, r);
            if (r[5]) tc[r[4:0] % TW] = tt[r[4:0] % TW];
        end
        if (bubbles) begin
            random_bits(5, r);
            m  = dac_code_pkg::therm_word_t'(1) << (r % TW);
            tt = tt ^ m; // Flip both halves so the pair stays complementary
            tc = tc ^ m;
        end
        pending_bt = bt;
        pending_bc = bc;
        pending_tt = tt;
        pending_tc = tc;
    endtask

    initial begin
        logic [31:0]               r;
        dac_code_pkg::therm_word_t tt;
        clkinb_binary_0 = 1'b0;
        pdb             = 1'b0;
        atb_ena         = dac_ctrl_pkg::atb_off;
        datainbin       = '0;
        datainbinb      = '1; // Complementary zero code
        dataintherm     = '0;
        datainthermb    = '1;
        {exp_bin, exp_binb, exp_therm, exp_thermb, exp_live, exp_sticky} = '0;
        exp_pdb_r = 1'b0;
        for (int i = 0; i < STAGES; i++) in_flight.push_back('0);
        repeat (RESET_CYCLES) @(posedge clkin_binary_0);
        @(negedge clkin_binary_0);
        clkinb_binary_0 = 1'b1;
        pdb             = 1'b1;
        atb_ena         = dac_ctrl_pkg::atb_live;

        for (int k = 0; k <= TW; k++) begin // Every fill, all zeros to all ones
            random_bits(BW, r);
            tt = therm_fill(k);
            drive_cycle(dac_code_pkg::bin_word_t'(r), ~dac_code_pkg::bin_word_t'(r), tt, ~tt,
                        1'b1, k[0] ? dac_ctrl_pkg::atb_sticky : dac_ctrl_pkg::atb_live);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            random_word(1'b1, 1'b0);
            drive_cycle(pending_bt, pending_bc, pending_tt, pending_tc, 1'b1,
                        (i % 4 == 3) ? dac_ctrl_pkg::atb_sticky : dac_ctrl_pkg::atb_live);
        end
        for (int i = 0; i < N_BUBBLE; i++) begin
            random_word(1'b0, 1'b1);
            drive_cycle(pending_bt, pending_bc, pending_tt, pending_tc, 1'b1,
                        i[0] ? dac_ctrl_pkg::atb_live_alt : dac_ctrl_pkg::atb_live);
        end
        for (int i = 0; i < N_PDB; i++) begin // Low for 3 of every 8 cycles
            random_word(1'b1, 1'b1);
            drive_cycle(pending_bt, pending_bc, pending_tt, pending_tc, (i % 8) >= 3,
                        dac_ctrl_pkg::atb_live);
        end
        for (int i = 0; i < N_ATB; i++) begin
            random_word(1'b1, 1'b1);
            drive_cycle(pending_bt, pending_bc, pending_tt, pending_tc, 1'b1,
                        dac_ctrl_pkg::atb_sel_t'(2'(i / 3)));
        end
        for (int i = 0; i < STAGES + 2; i++) begin // Drain the pipeline
            random_word(1'b0, 1'b0);
            drive_cycle(pending_bt, pending_bc, pending_tt, pending_tc, 1'b1,
                        dac_ctrl_pkg::atb_sticky);
        end

        $display("Checks finished: %0d output mismatches, %0d property failures",
                 errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/dac_code_pkg.sv
src/dac_ctrl_pkg.sv
src/code_decode.sv
src/resync_stage.sv
src/switch_driver.sv
src/rsync_latch_top.sv
dv/rsync_props.sv
dv/rsync_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; the run passes only if the testbench reports a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rsync_tb -f list.f \
    && ./obj_dir/Vrsync_tb +verilator+error+limit+1000 | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* src/code_decode.sv */
`default_nettype none

module code_decode (
    input  dac_code_pkg::bin_word_t   datainbin,
    input  dac_code_pkg::bin_word_t   datainbinb,
    input  dac_code_pkg::therm_word_t dataintherm,
    input  dac_code_pkg::therm_word_t datainthermb,
    output dac_ctrl_pkg::fault_t      fault
);

    localparam int THERM_W = $bits(dac_code_pkg::therm_word_t);

    logic bin_pair_fault;
    logic therm_pair_fault;
    logic therm_bubble;

    // A bit and its complement that agree leave the cell undefined
    assign bin_pair_fault   = |(~(datainbin ^ datainbinb));
    assign therm_pair_fault = |(~(dataintherm ^ datainthermb));

    // A set bit above a clear one breaks the fill, all zeros and all ones are fine
    always_comb begin
        therm_bubble = 1'b0;
        for (int i = 1; i < THERM_W; i++) begin
            if (dataintherm[i] && !dataintherm[i-1]) begin
                therm_bubble = 1'b1;
            end
        end
    end

    always_comb begin
        fault = '0;
        fault[dac_ctrl_pkg::FLT_BIN_PAIR]     = bin_pair_fault;
        fault[dac_ctrl_pkg::FLT_THERM_PAIR]   = therm_pair_fault;
        fault[dac_ctrl_pkg::FLT_THERM_BUBBLE] = therm_bubble;
    end

endmodule

`default_nettype wire

/* src/dac_code_pkg.sv */
`default_nettype none

`include "rsync_settings.svh"

package dac_code_pkg;

    // One half of the binary pair, bit 0 drives the redundant cell
    typedef logic [`BIN_WIDTH-1:0] bin_word_t;

    // One half of the thermometric pair, valid codes fill upward from bit 0
    typedef logic [`THERM_WIDTH-1:0] therm_word_t;

endpackage

`default_nettype wire

/* src/dac_ctrl_pkg.sv */
`default_nettype none

package dac_ctrl_pkg;

    localparam int FAULT_W          = 3;
    localparam int FLT_BIN_PAIR     = 0; // A binary bit equals its complement
    localparam int FLT_THERM_PAIR   = 1; // A thermometric bit equals its complement
    localparam int FLT_THERM_BUBBLE = 2; // Thermometric word is not a fill from bit 0

    typedef logic [FAULT_W-1:0] fault_t;

    // Digital test bus selection
    typedef enum logic [1:0] {
        atb_off      = 2'b00, // Both buses zero
        atb_live     = 2'b01, // Live flags on atb1
        atb_live_alt = 2'b10, // Same as atb_live
        atb_sticky   = 2'b11  // Sticky flags on both buses
    } atb_sel_t;

endpackage

`default_nettype wire

/* src/resync_stage.sv */
`default_nettype none

module resync_stage #(
    parameter type payload_t = logic,
    parameter int  STAGES    = 1      // Register depth, at least 1
) (
    input  wire      clkin_binary_0,
    input  wire      clkinb_binary_0, // Active-low asynchronous reset
    input  payload_t d,
    output payload_t q
);

    payload_t pipe [STAGES]; // Index 0 samples the input

    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            for (int i = 0; i < STAGES; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < STAGES; i++) begin
                pipe[i] <= pipe[i-1]; // Shift one stage per clock
            end
        end
    end

    assign q = pipe[STAGES-1];

endmodule

`default_nettype wire

/* src/rsync_latch_top.sv */
`default_nettype none

`include "rsync_settings.svh"

module rsync_latch_top (
    input  dac_code_pkg::bin_word_t   datainbin,
    input  dac_code_pkg::bin_word_t   datainbinb,
    input  dac_code_pkg::therm_word_t dataintherm,
    input  dac_code_pkg::therm_word_t datainthermb,
    input  wire                       pdb,             // Power down when low
    input  dac_ctrl_pkg::atb_sel_t    atb_ena,         // Test bus selection
    input  wire                       clkin_binary_0,
    input  wire                       clkinb_binary_0, // Active-low asynchronous reset
    output dac_code_pkg::bin_word_t   dataoutbin,
    output dac_code_pkg::bin_word_t   dataoutbinb,
    output dac_code_pkg::therm_word_t dataouttherm,
    output dac_code_pkg::therm_word_t dataoutthermb,
    output dac_ctrl_pkg::fault_t      atb1,
    output dac_ctrl_pkg::fault_t      atb0
);

    localparam int BIN_PAIR_W   = 2 * $bits(dac_code_pkg::bin_word_t);
    localparam int THERM_PAIR_W = 2 * $bits(dac_code_pkg::therm_word_t);

    dac_ctrl_pkg::fault_t    fault_d;
    dac_ctrl_pkg::fault_t    fault_q;
    logic [BIN_PAIR_W-1:0]   bin_pair_q;
    logic [THERM_PAIR_W-1:0] therm_pair_q;

    code_decode u_decode (
        .datainbin    (datainbin),
        .datainbinb   (datainbinb),
        .dataintherm  (dataintherm),
        .datainthermb (datainthermb),
        .fault        (fault_d)
    );

    // Binary pair travels as {true, complement}
    resync_stage #(
        .payload_t (logic [BIN_PAIR_W-1:0]),
        .STAGES    (`RSYNC_STAGES)
    ) u_sync_bin (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .d               ({datainbin, datainbinb}),
        .q               (bin_pair_q)
    );

    resync_stage #(
        .payload_t (logic [THERM_PAIR_W-1:0]),
        .STAGES    (`RSYNC_STAGES)
    ) u_sync_therm (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .d               ({dataintherm, datainthermb}),
        .q               (therm_pair_q)
    );

    // Flags ride alongside so they stay with their word
    resync_stage #(
        .payload_t (dac_ctrl_pkg::fault_t),
        .STAGES    (`RSYNC_STAGES)
    ) u_sync_fault (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .d               (fault_d),
        .q               (fault_q)
    );

    switch_driver #(
        .BIN_PAIR_W   (BIN_PAIR_W),
        .THERM_PAIR_W (THERM_PAIR_W)
    ) u_driver (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .pdb             (pdb),
        .atb_ena         (atb_ena),
        .bin_pair_q      (bin_pair_q),
        .therm_pair_q    (therm_pair_q),
        .fault_q         (fault_q),
        .dataoutbin      (dataoutbin),
        .dataoutbinb     (dataoutbinb),
        .dataouttherm    (dataouttherm),
        .dataoutthermb   (dataoutthermb),
        .atb1            (atb1),
        .atb0            (atb0)
    );

endmodule

`default_nettype wire

/* src/rsync_settings.svh */
`ifndef RSYNC_SETTINGS_SVH
`define RSYNC_SETTINGS_SVH

// Binary cells, bit 0 is the redundant LSB cell
`define BIN_WIDTH 7

// Thermometric unary cells
`define THERM_WIDTH 17

// Resync registers ahead of the output register, at least 1
`define RSYNC_STAGES 2

`endif

/* src/switch_driver.sv */
`default_nettype none

module switch_driver #(
    parameter int BIN_PAIR_W   = 2 * $bits(dac_code_pkg::bin_word_t),
    parameter int THERM_PAIR_W = 2 * $bits(dac_code_pkg::therm_word_t)
) (
    input  wire                       clkin_binary_0,
    input  wire                       clkinb_binary_0, // Active-low asynchronous reset
    input  wire                       pdb,             // Power down when low
    input  dac_ctrl_pkg::atb_sel_t    atb_ena,
    input  wire [BIN_PAIR_W-1:0]      bin_pair_q,      // {true, complement}
    input  wire [THERM_PAIR_W-1:0]    therm_pair_q,    // {true, complement}
    input  dac_ctrl_pkg::fault_t      fault_q,
    output dac_code_pkg::bin_word_t   dataoutbin,
    output dac_code_pkg::bin_word_t   dataoutbinb,
    output dac_code_pkg::therm_word_t dataouttherm,
    output dac_code_pkg::therm_word_t dataoutthermb,
    output dac_ctrl_pkg::fault_t      atb1,
    output dac_ctrl_pkg::fault_t      atb0
);

    logic [BIN_PAIR_W-1:0]   bin_r;
    logic [THERM_PAIR_W-1:0] therm_r;
    dac_ctrl_pkg::fault_t    live_r;
    dac_ctrl_pkg::fault_t    sticky_r;
    logic                    pdb_r;     // Aligns test bus gating with the data outputs
    dac_ctrl_pkg::fault_t    atb1_sel;
    dac_ctrl_pkg::fault_t    atb0_sel;

    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            bin_r    <= '0;
            therm_r  <= '0;
            live_r   <= '0;
            sticky_r <= '0;
            pdb_r    <= 1'b0;
        end else begin
            pdb_r <= pdb;
            if (pdb) begin
                bin_r    <= bin_pair_q;
                therm_r  <= therm_pair_q;
                live_r   <= fault_q;
                sticky_r <= sticky_r | fault_q; // Words dropped in power-down never count
            end else begin
                bin_r   <= '0; // No cell selected
                therm_r <= '0;
            end
        end
    end

    // Split the registered pairs onto the switch lines
    assign dataoutbin    = bin_r[BIN_PAIR_W-1 -: BIN_PAIR_W/2];
    assign dataoutbinb   = bin_r[BIN_PAIR_W/2-1:0];
    assign dataouttherm  = therm_r[THERM_PAIR_W-1 -: THERM_PAIR_W/2];
    assign dataoutthermb = therm_r[THERM_PAIR_W/2-1:0];

    always_comb begin
        case (atb_ena)
            dac_ctrl_pkg::atb_live,
            dac_ctrl_pkg::atb_live_alt: begin
                atb1_sel = live_r;
                atb0_sel = '0;
            end
            dac_ctrl_pkg::atb_sticky: begin
                atb1_sel = sticky_r;
                atb0_sel = sticky_r;
            end
            default: begin          // atb_off
                atb1_sel = '0;
                atb0_sel = '0;
            end
        endcase
    end

    assign atb1 = pdb_r ? atb1_sel : '0; // Test bus quiet while powered down
    assign atb0 = pdb_r ? atb0_sel : '0;

endmodule

`default_nettype wire
